/* Bender.yml */
package:
  name: branch_predictor

sources:
  - design/bp_pkg.sv
  - design/local_predictor.sv
  - design/global_predictor.sv
  - design/tournament_selector.sv
  - design/branch_predictor.sv
  - target: test
    files:
      - testbench/tb_branch_predictor.sv

/* design/bp_pkg.sv */
package bp_pkg;

    localparam int XLEN             = 32;
    localparam int ALIGN_BITS       = 2;                       // 32-bit instructions
    localparam int LOCAL_INDEX_BITS = 8;
    localparam int LOCAL_ENTRIES    = 2 ** LOCAL_INDEX_BITS;   // one history per index
    localparam int LOCAL_HIST_BITS  = 8;
    localparam int PATTERN_ENTRIES  = 2 ** LOCAL_HIST_BITS;    // addressed by a history
    localparam int GLOBAL_HIST_BITS = 8;
    localparam int GLOBAL_ENTRIES   = 2 ** GLOBAL_HIST_BITS;
    localparam int CHOOSER_ENTRIES  = 2 ** LOCAL_INDEX_BITS;   // shares the local index

    typedef logic [1:0]                  counter_t;
    typedef logic [LOCAL_HIST_BITS-1:0]  local_hist_t;
    typedef logic [GLOBAL_HIST_BITS-1:0] global_hist_t;

    localparam counter_t CTR_MAX  = 2'd3;   // strongly taken / strongly favor local
    localparam counter_t CTR_MIN  = 2'd0;
    localparam counter_t CTR_INIT = 2'd2;   // weakly taken / weakly favor local

    typedef struct packed {
        logic [XLEN-LOCAL_INDEX_BITS-ALIGN_BITS-1:0] upper;
        logic [LOCAL_INDEX_BITS-1:0]                 local_index;
        logic [ALIGN_BITS-1:0]                       align;
    } pc_local_t;

    typedef struct packed {
        global_hist_t                       global_tag;   // top byte of the pc
        logic [XLEN-GLOBAL_HIST_BITS-1:0]   remainder;
    } pc_global_t;

    // one pc word, read by the local side and by the global side
    typedef union packed {
        pc_local_t  local_view;
        pc_global_t global_view;
    } pc_view_u;

    typedef struct packed {
        logic     valid;
        pc_view_u pc;
    } predict_req_t;

    typedef struct packed {
        logic     valid;
        pc_view_u pc;
        logic     taken;          // actual outcome
        logic     local_taken;    // what the local side predicted
        logic     global_taken;   // what the global side predicted
        logic     cond_branch;
    } resolve_t;

    typedef struct packed {
        logic valid;
        logic local_taken;
        logic global_taken;
        logic taken;
    } prediction_t;

    // one saturating step toward the outcome
    function automatic counter_t ctr_update(counter_t ctr, logic up);
        if (up && ctr != CTR_MAX) begin
            return ctr + 2'd1;
        end
        if (!up && ctr != CTR_MIN) begin
            return ctr - 2'd1;
        end
        return ctr;
    endfunction

    function automatic logic ctr_taken(counter_t ctr);
        return ctr >= CTR_INIT;   // weakly taken and above
    endfunction

endpackage

/* design/branch_predictor.sv */
module branch_predictor import bp_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  predict_req_t predict_req,
    input  resolve_t     resolve,
    output prediction_t  prediction
);

    logic local_taken;    // combinational stage 1 lookups
    logic global_taken;

    // both predictors look up the same pc in parallel in stage 1

    local_predictor local_predictor0 (
        .clock       (clock),
        .reset       (reset),
        .lookup_pc   (predict_req.pc),
        .resolve     (resolve),
        .local_taken (local_taken)
    );

    global_predictor global_predictor0 (
        .clock        (clock),
        .reset        (reset),
        .lookup_pc    (predict_req.pc),
        .resolve      (resolve),
        .global_taken (global_taken)
    );

    // the chooser picks a side and registers the answer in stage 2
    tournament_selector tournament_selector0 (
        .clock        (clock),
        .reset        (reset),
        .predict_req  (predict_req),
        .local_taken  (local_taken),
        .global_taken (global_taken),
        .resolve      (resolve),
        .prediction   (prediction)
    );

endmodule

/* design/global_predictor.sv */
module global_predictor import bp_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  pc_view_u lookup_pc,
    input  resolve_t resolve,
    output logic     global_taken
);

    global_hist_t ghist;                           // shared by every branch
    counter_t     pattern_table [GLOBAL_ENTRIES];

    global_hist_t lookup_idx;
    global_hist_t train_idx;
    logic         train;

    // gshare style index from history xor top byte of pc
    assign lookup_idx   = ghist ^ lookup_pc.global_view.global_tag;
    assign global_taken = ctr_taken(pattern_table[lookup_idx]);

    assign train     = resolve.valid && resolve.cond_branch;
    assign train_idx = ghist ^ resolve.pc.global_view.global_tag;   // pre-update history

    always_ff @(posedge clock) begin
        if (reset) begin
            ghist <= '0;
        end else if (train) begin
            ghist <= {resolve.taken, ghist[GLOBAL_HIST_BITS-1:1]};   // outcome into msb
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < GLOBAL_ENTRIES; i++) begin
                pattern_table[i] <= CTR_INIT;
            end
        end else if (train) begin
            pattern_table[train_idx] <= ctr_update(pattern_table[train_idx],
                                                   resolve.taken);
        end
    end

    // history may only move on the edge after a conditional resolve
    a_ghist_moves_on_train: assert property (
        @(posedge clock) disable iff (reset)
        !$stable(ghist) |-> $past(train) && !$isunknown(ghist)
    ) else $error("global history changed without a defined training resolve");

endmodule

/* design/local_predictor.sv */
module local_predictor import bp_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  pc_view_u lookup_pc,
    input  resolve_t resolve,
    output logic     local_taken
);

    local_hist_t hist_table    [LOCAL_ENTRIES];     // per-branch history
    counter_t    pattern_table [PATTERN_ENTRIES];   // shared pattern counters

    logic [LOCAL_INDEX_BITS-1:0] lookup_idx;
    logic [LOCAL_INDEX_BITS-1:0] train_idx;
    local_hist_t                 lookup_hist;
    local_hist_t                 train_hist;
    logic                        train;

    assign lookup_idx  = lookup_pc.local_view.local_index;
    assign lookup_hist = hist_table[lookup_idx];

    // history of the branch picks the pattern counter
    assign local_taken = ctr_taken(pattern_table[lookup_hist]);

    assign train      = resolve.valid && resolve.cond_branch;
    assign train_idx  = resolve.pc.local_view.local_index;
    assign train_hist = hist_table[train_idx];   // history before this outcome

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < LOCAL_ENTRIES; i++) begin
                hist_table[i] <= '0;   // all not taken
            end
        end else if (train) begin
            // newest outcome lands in the msb
            hist_table[train_idx] <= {resolve.taken, train_hist[LOCAL_HIST_BITS-1:1]};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int j = 0; j < PATTERN_ENTRIES; j++) begin
                pattern_table[j] <= CTR_INIT;
            end
        end else if (train) begin
            pattern_table[train_hist] <= ctr_update(pattern_table[train_hist],
                                                    resolve.taken);
        end
    end

    // every table entry comes out of reset defined
    a_local_known: assert property (
        @(posedge clock) disable iff (reset)
        !$isunknown(local_taken)
    ) else $error("local prediction is unknown after reset");

endmodule

/* design/tournament_selector.sv */
module tournament_selector import bp_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  predict_req_t predict_req,
    input  logic         local_taken,
    input  logic         global_taken,
    input  resolve_t     resolve,
    output prediction_t  prediction
);

    counter_t chooser_table [CHOOSER_ENTRIES];   // high half favors local

    logic [LOCAL_INDEX_BITS-1:0] lookup_idx;
    logic [LOCAL_INDEX_BITS-1:0] train_idx;
    logic                        chosen_taken;
    logic                        train;

    assign lookup_idx   = predict_req.pc.local_view.local_index;
    assign chosen_taken = ctr_taken(chooser_table[lookup_idx]) ? local_taken : global_taken;

    // only a disagreement says anything about which side is better
    assign train     = resolve.valid && resolve.cond_branch &&
                       (resolve.local_taken != resolve.global_taken);
    assign train_idx = resolve.pc.local_view.local_index;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < CHOOSER_ENTRIES; i++) begin
                chooser_table[i] <= CTR_INIT;
            end
        end else if (train) begin
            chooser_table[train_idx] <= ctr_update(chooser_table[train_idx],
                                                   resolve.local_taken == resolve.taken);
        end
    end

    // stage 2 output register
    always_ff @(posedge clock) begin
        if (reset) begin
            prediction.valid <= 1'b0;
        end else begin
            prediction.valid <= predict_req.valid;
        end
        if (predict_req.valid) begin
            prediction.local_taken  <= local_taken;
            prediction.global_taken <= global_taken;
            prediction.taken        <= chosen_taken;
        end
    end

    a_one_cycle_latency: assert property (
        @(posedge clock) disable iff (reset)
        prediction.valid |-> $past(predict_req.valid) && !$isunknown(prediction)
    ) else $error("prediction valid without an earlier request or with unknown bits");

endmodule

/* sim.f */
design/bp_pkg.sv
design/local_predictor.sv
design/global_predictor.sv
design/tournament_selector.sv
design/branch_predictor.sv
testbench/tb_branch_predictor.sv

/* testbench/bp_testdata.txt */
# columns: test kind pc r_taken r_local r_global r_cond e_local e_global e_taken
# kind P predict, R resolve, B predict and resolve in one cycle, I idle; unused columns are 0
# test 1 reset state
1 P 00000040 0 0 0 0 1 1 1
1 I 00000000 0 0 0 0 0 0 0
1 P fffffffc 0 0 0 0 1 1 1
# test 2 local learning, non-conditional resolves leave the tables alone
2 R 00000040 1 1 1 0 0 0 0
2 R 00000040 1 1 1 0 0 0 0
2 P 00000040 0 0 0 0 1 1 1
2 R 00000040 0 1 1 1 0 0 0
2 R 00000040 0 1 1 1 0 0 0
2 P 00000040 0 0 0 0 0 0 0
2 R 00000040 1 1 1 0 0 0 0
2 P 00000040 0 0 0 0 0 0 0
# test 3 saturation, history fills with ones and counter ff is hit twice
3 R 00000100 1 1 1 1 0 0 0
3 R 00000100 1 1 1 1 0 0 0
3 R 00000100 1 1 1 1 0 0 0
3 R 00000100 1 1 1 1 0 0 0
3 R 00000100 1 1 1 1 0 0 0
3 R 00000100 1 1 1 1 0 0 0
3 R 00000100 1 1 1 1 0 0 0
3 R 00000100 1 1 1 1 0 0 0
3 R 00000100 1 1 1 1 0 0 0
3 R 00000100 1 1 1 1 0 0 0
3 R 00000100 0 1 1 1 0 0 0
3 P 00000100 0 0 0 0 1 1 1
3 P 80000100 0 0 0 0 1 1 1
# test 4 global indexing, history 80 xor tags 90 and a0 hits entries 10 and 20
4 R 10000040 0 1 1 1 0 0 0
4 R 10000040 0 1 1 1 0 0 0
4 P 10000040 0 0 0 0 0 0 0
4 P 20000080 0 0 0 0 0 1 0
4 R 20000080 1 1 1 1 0 0 0
4 P 90000040 0 0 0 0 0 0 0
4 P a0000080 0 0 0 0 1 1 1
# test 5 chooser, agreeing resolves first, then local wrong and global right
5 R 00000200 0 1 1 1 0 0 0
5 R 00000200 0 1 1 1 0 0 0
5 P 55000200 0 0 0 0 0 1 0
5 R 00000200 0 1 0 1 0 0 0
5 P 55000200 0 0 0 0 0 1 1
# test 6 same-cycle predict and resolve, then back-to-back requests
6 B 00000300 0 1 1 1 1 1 1
6 B 00000300 0 1 1 1 0 0 0
6 P 00000300 0 0 0 0 0 0 0
6 P 33000300 0 0 0 0 0 1 0
6 P 00000300 0 0 0 0 0 0 0
6 I 00000000 0 0 0 0 0 0 0

/* testbench/tb_branch_predictor.sv */
module tb_branch_predictor import bp_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DRAIN_LIMIT = 10;   // cycles allowed for the last prediction of a test

    typedef struct packed {
        int unsigned     cycle;        // cycle in which the request was driven
        logic [XLEN-1:0] pc;
        logic            local_taken;
        logic            global_taken;
        logic            taken;
    } expect_t;

    logic         clock;
    logic         reset;
    predict_req_t predict_req;
    resolve_t     resolve;
    prediction_t  prediction;

    expect_t     exp_q[$];   // requests still waiting for an answer
    expect_t     head;
    int unsigned cycle_count;
    int          test_checks;
    int          test_errors;
    int          total_checks;
    int          total_errors;
    int          tests_run;
    int          tests_passed;

    branch_predictor DUT (
        .clock       (clock),
        .reset       (reset),
        .predict_req (predict_req),
        .resolve     (resolve),
        .prediction  (prediction)
    );

    always #10 clock = ~clock;   // 20 ns period

    task automatic next_cycle();
        @(posedge clock);
        cycle_count++;
    endtask

    task automatic flag_mismatch(input string msg);
        $display("Error at %0d ns: %s", $time, msg);
        test_errors++;
        total_errors++;
    endtask

    task automatic note_failure(input string msg);
        $display("%s (at %0d ns)", msg, $time);
        test_errors++;
        total_errors++;
    endtask

    task automatic compare_bit(input string name, input logic got, input logic want,
                               input logic [XLEN-1:0] pc);
        test_checks++;
        total_checks++;
        assert (got === want) else begin
            flag_mismatch($sformatf("%s prediction for pc %h is %b, expected %b",
                                    name, pc, got, want));
        end
    endtask

    task automatic drive_idle();
        predict_req.valid <= 1'b0;
        resolve.valid     <= 1'b0;
    endtask

    task automatic apply_line(input logic [7:0] kind, input logic [XLEN-1:0] pc,
                              input logic r_taken, input logic r_local,
                              input logic r_global, input logic r_cond,
                              input logic e_local, input logic e_global,
                              input logic e_taken);
        expect_t entry;
        if (kind != "P" && kind != "R" && kind != "B" && kind != "I") begin
            note_failure($sformatf("test data line has an unknown kind %s", kind));
        end
        predict_req.valid    <= (kind == "P" || kind == "B");
        predict_req.pc       <= pc;
        resolve.valid        <= (kind == "R" || kind == "B");
        resolve.pc           <= pc;
        resolve.taken        <= r_taken;
        resolve.local_taken  <= r_local;
        resolve.global_taken <= r_global;
        resolve.cond_branch  <= r_cond;
        if (kind == "P" || kind == "B") begin
            entry.cycle        = cycle_count;
            entry.pc           = pc;
            entry.local_taken  = e_local;
            entry.global_taken = e_global;
            entry.taken        = e_taken;
            exp_q.push_back(entry);
        end
    endtask

    task automatic start_test();
        test_checks = 0;
        test_errors = 0;
        reset <= 1'b1;
        drive_idle();
        repeat (3) next_cycle();
        reset <= 1'b0;
    endtask

    task automatic finish_test(input int test_id);
        int waited;
        waited = 0;
        next_cycle();
        drive_idle();
        while (exp_q.size() > 0 && waited < DRAIN_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (exp_q.size() > 0) begin
            note_failure($sformatf("prediction never became valid in test %0d", test_id));
            exp_q.delete();
        end
        tests_run++;
        if (test_errors == 0) begin
            tests_passed++;
        end
        $display("test %0d done: %0d checks, %0d errors", test_id, test_checks, test_errors);
    endtask

    // outputs are sampled mid cycle, away from the driving edge
    always @(negedge clock) begin
        if (exp_q.size() > 0 && cycle_count - exp_q[0].cycle >= 1) begin
            if (cycle_count - exp_q[0].cycle == 1) begin
                test_checks++;
                total_checks++;
                assert (prediction.valid === 1'b1) else begin
                    note_failure($sformatf("no prediction one cycle after the request for pc %h",
                                           exp_q[0].pc));
                end
            end
            if (prediction.valid === 1'b1) begin
                head = exp_q.pop_front();
                compare_bit("local", prediction.local_taken, head.local_taken, head.pc);
                compare_bit("global", prediction.global_taken, head.global_taken, head.pc);
                compare_bit("chosen", prediction.taken, head.taken, head.pc);
            end
        end else begin
            assert (prediction.valid !== 1'b1) else begin
                note_failure("prediction valid without a request one cycle earlier");
            end
        end
    end

    initial begin
        int               fd;
        int               fields;
        int               current_test;
        int               line_test;
        logic [7:0]       kind;
        logic [XLEN-1:0]  pc;
        logic             r_taken;
        logic             r_local;
        logic             r_global;
        logic             r_cond;
        logic             e_local;
        logic             e_global;
        logic             e_taken;
        logic [8*160-1:0] text;
        clock        = 1'b0;
        reset        = 1'b1;
        predict_req  = '0;
        resolve      = '0;
        cycle_count  = 0;
        total_checks = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_passed = 0;
        current_test = 0;
        fd = $fopen("testbench/bp_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/bp_testdata.txt for reading");
            $display("Checks failed");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(text, fd) != 0) begin
                    fields = $sscanf(text, "%d %s %h %d %d %d %d %d %d %d", line_test, kind,
                                     pc, r_taken, r_local, r_global, r_cond,
                                     e_local, e_global, e_taken);
                    if (fields == 10) begin   // comment and blank lines fall through
                        if (line_test != current_test) begin
                            if (current_test != 0) begin
                                finish_test(current_test);
                            end
                            start_test();
                            current_test = line_test;
                        end
                        next_cycle();
                        apply_line(kind, pc, r_taken, r_local, r_global, r_cond,
                                   e_local, e_global, e_taken);
                    end
                end
            end
            $fclose(fd);
            if (current_test != 0) begin
                finish_test(current_test);
            end
            $display("tests %0d, passed %0d, checks %0d, errors %0d",
                     tests_run, tests_passed, total_checks, total_errors);
            if (total_errors == 0 && total_checks > 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

endmodule
